// File: aes_dec_defs.svh
`ifndef AES_DEC_DEFS_SVH
`define AES_DEC_DEFS_SVH

// --------------------------------------------------
// aes-128 cipher dimensions

`define AES_BLOCK_W   128
`define AES_WORD_W    32

// rounds and round keys
`define AES_NR        10
`define AES_NUM_RKEYS (`AES_NR + 1)

// all round keys side by side, key 0 on top
`define AES_SCHED_W   (`AES_NUM_RKEYS * `AES_BLOCK_W)

`endif

// File: aes_dec_pkg.sv
`default_nettype none

`include "aes_dec_defs.svh"

package aes_dec_pkg;

  // --------------------------------------------------
  // types

  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;
  typedef logic [`AES_WORD_W-1:0]  aes_word_t;
  typedef logic [7:0]              aes_byte_t;
  typedef logic [`AES_SCHED_W-1:0] aes_sched_t;
  typedef logic [3:0]              round_cnt_t;

  typedef enum logic [1:0] {
    PH_LOAD  = 2'd0,  // waiting for first edge after reset
    PH_ROUND = 2'd1,
    PH_FINAL = 2'd2   // last round, output held
  } dec_phase_t;

  // --------------------------------------------------
  // gf(2^8) arithmetic

  // poly x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t x;
    acc = '0;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ x;
      end
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);  // xtime
    end
    return acc;
  endfunction

  // a^254, which also maps 0 to 0
  function automatic aes_byte_t gf_inv(input aes_byte_t a);
    aes_byte_t sq;
    aes_byte_t res;
    sq = a;
    res = 8'h01;
    for (int i = 0; i < 7; i++) begin
      sq = gf_mul(sq, sq);   // a^2, a^4 .. a^128
      res = gf_mul(res, sq);
    end
    return res;
  endfunction

  function automatic aes_byte_t rotl_byte(input aes_byte_t v, input int n);
    return aes_byte_t'((v << n) | (v >> (8 - n)));
  endfunction

  // --------------------------------------------------
  // s-boxes

  function automatic aes_byte_t sbox_byte(input aes_byte_t a);
    aes_byte_t b;
    b = gf_inv(a);
    return b ^ rotl_byte(b, 1) ^ rotl_byte(b, 2) ^ rotl_byte(b, 3) ^
           rotl_byte(b, 4) ^ 8'h63;
  endfunction

  function automatic aes_byte_t inv_sbox_byte(input aes_byte_t s);
    aes_byte_t b;
    // undo the affine step first
    b = rotl_byte(s, 1) ^ rotl_byte(s, 3) ^ rotl_byte(s, 6) ^ 8'h05;
    return gf_inv(b);
  endfunction

  // --------------------------------------------------
  // block transforms

  // byte k sits at bits [127-8k -: 8], column major
  function automatic aes_block_t inv_shift_rows(input aes_block_t s);
    aes_block_t r;
    int src;
    r = '0;
    for (int col = 0; col < 4; col++) begin
      for (int row = 0; row < 4; row++) begin
        src = 4 * ((col - row + 4) % 4) + row;  // row shifted right by row index
        r[`AES_BLOCK_W-1 - 8*(4*col + row) -: 8] = s[`AES_BLOCK_W-1 - 8*src -: 8];
      end
    end
    return r;
  endfunction

  function automatic aes_block_t inv_sub_block(input aes_block_t s);
    aes_block_t r;
    r = '0;
    for (int k = 0; k < 16; k++) begin
      r[`AES_BLOCK_W-1 - 8*k -: 8] = inv_sbox_byte(s[`AES_BLOCK_W-1 - 8*k -: 8]);
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: aes_key_expand.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module aes_key_expand import aes_dec_pkg::*; (
  input  aes_block_t key,
  output aes_sched_t key_sched
);

  // round constants, indexed by word number / 4
  localparam aes_byte_t rcon_tab [1:`AES_NR] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // --------------------------------------------------
  // 44 schedule words, each in its own block

  genvar i;
  generate
    for (i = 0; i < 4 * `AES_NUM_RKEYS; i++) begin : g_word
      aes_word_t word;

      if (i < 4) begin : g_key
        assign word = key[`AES_BLOCK_W-1 - i*`AES_WORD_W -: `AES_WORD_W];
      end else if (i % 4 == 0) begin : g_rot
        aes_word_t rot;
        aes_word_t sub;
        assign rot = {g_word[i-1].word[23:0], g_word[i-1].word[31:24]};  // rotword
        assign sub = {sbox_byte(rot[31:24]),
                      sbox_byte(rot[23:16]),
                      sbox_byte(rot[15:8]),
                      sbox_byte(rot[7:0])};
        assign word = g_word[i-4].word ^ sub ^ {rcon_tab[i/4], 24'h000000};
      end else begin : g_xor
        assign word = g_word[i-4].word ^ g_word[i-1].word;
      end

      // word 0 lands in the top bits
      assign key_sched[`AES_SCHED_W-1 - i*`AES_WORD_W -: `AES_WORD_W] = word;
    end
  endgenerate

endmodule

`default_nettype wire

// File: aes_inv_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module aes_inv_round import aes_dec_pkg::*; (
  input  aes_block_t round_state,
  input  aes_block_t round_key,
  output aes_block_t round_out
);

  aes_block_t keyed;

  // key added before the column mix, as in the inverse cipher
  assign keyed = inv_sub_block(inv_shift_rows(round_state)) ^ round_key;

  // --------------------------------------------------
  // invmixcolumns, one column per block

  genvar c;
  generate
    for (c = 0; c < 4; c++) begin : g_col
      aes_byte_t a0;
      aes_byte_t a1;
      aes_byte_t a2;
      aes_byte_t a3;

      assign a0 = keyed[`AES_BLOCK_W-1 - c*`AES_WORD_W -: 8];
      assign a1 = keyed[`AES_BLOCK_W-9 - c*`AES_WORD_W -: 8];
      assign a2 = keyed[`AES_BLOCK_W-17 - c*`AES_WORD_W -: 8];
      assign a3 = keyed[`AES_BLOCK_W-25 - c*`AES_WORD_W -: 8];

      // circulant matrix 0e 0b 0d 09
      assign round_out[`AES_BLOCK_W-1 - c*`AES_WORD_W -: 8] =
        gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
      assign round_out[`AES_BLOCK_W-9 - c*`AES_WORD_W -: 8] =
        gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
      assign round_out[`AES_BLOCK_W-17 - c*`AES_WORD_W -: 8] =
        gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
      assign round_out[`AES_BLOCK_W-25 - c*`AES_WORD_W -: 8] =
        gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
    end
  endgenerate

endmodule

`default_nettype wire

// File: aes_dec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module aes_dec_sequencer import aes_dec_pkg::*; (
  input  logic       clk,
  input  logic       decReset,
  input  aes_block_t ct_in,
  input  aes_sched_t key_sched,
  input  aes_block_t round_out,
  output aes_block_t round_state,
  output aes_block_t round_key,
  output aes_block_t pt_out
);

  dec_phase_t phase;
  round_cnt_t round_cnt;
  round_cnt_t key_idx;
  aes_block_t last_round;

  // --------------------------------------------------
  // round key select

  // cnt 0 -> key 10, cnt 10 -> key 0
  assign key_idx   = round_cnt_t'(`AES_NR) - round_cnt;
  assign round_key = key_sched[`AES_SCHED_W-1 - int'(key_idx)*`AES_BLOCK_W -: `AES_BLOCK_W];

  // final round has no column mix
  assign last_round = inv_sub_block(inv_shift_rows(round_state)) ^ round_key;

  // --------------------------------------------------
  // phase machine

  always_ff @(posedge clk or posedge decReset) begin
    if (decReset) begin
      phase       <= PH_LOAD;
      round_cnt   <= '0;
      round_state <= '0;
      pt_out      <= '0;
    end else begin
      case (phase)
        PH_LOAD: begin
          round_state <= ct_in ^ round_key;  // initial key addition
          round_cnt   <= round_cnt + round_cnt_t'(1);
          phase       <= PH_ROUND;
        end
        PH_ROUND: begin
          round_state <= round_out;
          round_cnt   <= round_cnt + round_cnt_t'(1);
          if (round_cnt == round_cnt_t'(`AES_NR - 1)) begin
            phase <= PH_FINAL;
          end
        end
        PH_FINAL: begin
          pt_out <= last_round;  // refreshed every edge, inputs held
        end
        default: begin
          phase <= PH_LOAD;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: aes_decrypt.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module aes_decrypt import aes_dec_pkg::*; (
  input  logic       clk,
  input  logic       decReset,
  input  aes_block_t ct_in,
  input  aes_block_t key,
  output aes_block_t pt_out
);

  aes_sched_t key_sched;
  aes_block_t round_state;
  aes_block_t round_key;
  aes_block_t round_out;

  aes_key_expand i_key_expand (
    .key       (key),
    .key_sched (key_sched)
  );

  aes_dec_sequencer i_sequencer (
    .clk         (clk),
    .decReset    (decReset),
    .ct_in       (ct_in),
    .key_sched   (key_sched),
    .round_out   (round_out),
    .round_state (round_state),
    .round_key   (round_key),
    .pt_out      (pt_out)
  );

  // shared for rounds 1 to 9
  aes_inv_round i_inv_round (
    .round_state (round_state),
    .round_key   (round_key),
    .round_out   (round_out)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam realtime half_period = 4.0;  // 8 ns period

  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: aes_decrypt_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module aes_decrypt_assert import aes_dec_pkg::*; (
  input logic       clk,
  input logic       decReset,
  input round_cnt_t round_cnt,
  input dec_phase_t phase,
  input aes_block_t pt_out
);

  int fail_cnt = 0;  // failed assertion attempts so far

  // --------------------------------------------------
  // sequencer rules

  cnt_in_range: assert property (@(posedge clk) disable iff (decReset)
    round_cnt <= round_cnt_t'(`AES_NR))
    else begin
      fail_cnt++;
      $error("round counter went past the last round");
    end

  // only a reset leaves the final phase
  final_holds: assert property (@(posedge clk) disable iff (decReset)
    phase == PH_FINAL |=> phase == PH_FINAL)
    else begin
      fail_cnt++;
      $error("sequencer left the final phase without a reset");
    end

  pt_zero_in_reset: assert property (@(posedge clk)
    decReset |=> pt_out == '0)
    else begin
      fail_cnt++;
      $error("pt_out not cleared while reset is held");
    end

endmodule

bind aes_dec_sequencer aes_decrypt_assert i_assert (
  .clk       (clk),
  .decReset  (decReset),
  .round_cnt (round_cnt),
  .phase     (phase),
  .pt_out    (pt_out)
);

`default_nettype wire

// File: tb_aes_decrypt.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_dec_defs.svh"

module tb_aes_decrypt import aes_dec_pkg::*; ();

  logic       clk;
  logic       decReset;
  aes_block_t ct_in;
  aes_block_t key;
  aes_block_t pt_out;

  int          mismatch_cnt;
  int          timeout_cnt;
  logic [31:0] lcg_state;
  logic [7:0]  fwd_sbox [256];
  logic [7:0]  inv_sbox [256];

  tb_clock_gen i_clock_gen (
    .clk (clk)
  );

  aes_decrypt i_aes_decrypt (
    .clk      (clk),
    .decReset (decReset),
    .ct_in    (ct_in),
    .key      (key),
    .pt_out   (pt_out)
  );

  // --------------------------------------------------
  // random numbers and reference model

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic aes_block_t random_block();
    aes_block_t b;
    b = '0;
    for (int i = 0; i < 4; i++) begin
      b = {b[95:0], lcg_next()};
    end
    return b;
  endfunction

  // shift and add, reduce by 0x11b
  function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    logic [7:0] bb;
    p = 8'h00;
    aa = a;
    bb = b;
    while (bb != 8'h00) begin
      if (bb[0]) begin
        p = p ^ aa;
      end
      aa = aa[7] ? ((aa << 1) ^ 8'h1b) : (aa << 1);
      bb = bb >> 1;
    end
    return p;
  endfunction

  // inverse found by search, inverse table from the forward one
  task automatic build_sbox_tables();
    logic [7:0] inv;
    logic [7:0] s;
    for (int a = 0; a < 256; a++) begin
      inv = 8'h00;
      for (int b = 1; b < 256; b++) begin
        if (gmul(8'(a), 8'(b)) == 8'h01) begin
          inv = 8'(b);
        end
      end
      for (int i = 0; i < 8; i++) begin
        s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
      end
      s = s ^ 8'h63;
      fwd_sbox[a] = s;
      inv_sbox[s] = 8'(a);
    end
  endtask

  function automatic aes_block_t model_decrypt(input aes_block_t ct, input aes_block_t k);
    logic [31:0] w [44];
    logic [31:0] t;
    logic [7:0]  rcon;
    logic [7:0]  st [16];
    logic [7:0]  tmp [16];
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  b3;
    aes_block_t  res;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = k[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        t = {fwd_sbox[t[23:16]], fwd_sbox[t[15:8]], fwd_sbox[t[7:0]], fwd_sbox[t[31:24]]}
            ^ {rcon, 24'h000000};
        rcon = gmul(rcon, 8'h02);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int n = 0; n < 16; n++) begin
      st[n] = ct[127-8*n -: 8] ^ w[40 + n/4][31-8*(n%4) -: 8];
    end
    for (int r = 9; r >= 0; r--) begin
      for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
          tmp[4*((c + row) % 4) + row] = st[4*c + row];  // row moves right
        end
      end
      for (int n = 0; n < 16; n++) begin
        st[n] = inv_sbox[tmp[n]] ^ w[4*r + n/4][31-8*(n%4) -: 8];
      end
      if (r > 0) begin
        for (int c = 0; c < 4; c++) begin
          b0 = st[4*c];
          b1 = st[4*c + 1];
          b2 = st[4*c + 2];
          b3 = st[4*c + 3];
          st[4*c]     = gmul(b0, 8'h0e) ^ gmul(b1, 8'h0b) ^ gmul(b2, 8'h0d) ^ gmul(b3, 8'h09);
          st[4*c + 1] = gmul(b0, 8'h09) ^ gmul(b1, 8'h0e) ^ gmul(b2, 8'h0b) ^ gmul(b3, 8'h0d);
          st[4*c + 2] = gmul(b0, 8'h0d) ^ gmul(b1, 8'h09) ^ gmul(b2, 8'h0e) ^ gmul(b3, 8'h0b);
          st[4*c + 3] = gmul(b0, 8'h0b) ^ gmul(b1, 8'h0d) ^ gmul(b2, 8'h09) ^ gmul(b3, 8'h0e);
        end
      end
    end
    for (int n = 0; n < 16; n++) begin
      res[127-8*n -: 8] = st[n];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // stimulus and checks

  task automatic check_value(input string name, input aes_block_t expected,
                             input aes_block_t actual);
    if (actual !== expected) begin
      mismatch_cnt++;
      $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // reset held 3 cycles, block inputs set with it
  task automatic start_block(input aes_block_t ct, input aes_block_t k);
    @(posedge clk);
    decReset <= 1'b1;
    ct_in    <= ct;
    key      <= k;
    repeat (3) begin
      @(negedge clk);
      check_value("pt_out", '0, pt_out);
    end
    @(posedge clk);
    decReset <= 1'b0;
  endtask

  // counts rising edges after release until pt_out turns nonzero
  task automatic wait_for_plaintext(output int edges);
    int n;
    n = 0;
    edges = -1;
    while (edges < 0 && n < 30) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (pt_out !== '0) begin
        edges = n;
      end
    end
    if (edges < 0) begin
      timeout_cnt++;
      $display("timeout: pt_out still zero %0d cycles after reset release", n);
    end
  endtask

  task automatic decrypt_and_check(input aes_block_t ct, input aes_block_t k,
                                   input aes_block_t expected);
    int edges;
    start_block(ct, k);
    wait_for_plaintext(edges);
    if (edges >= 0) begin
      check_value("latency", aes_block_t'(11), aes_block_t'(edges));
      check_value("pt_out", expected, pt_out);
      repeat (5) begin  // output must hold
        @(negedge clk);
        check_value("pt_out", expected, pt_out);
      end
    end
  endtask

  task automatic abort_mid_block(input aes_block_t ct, input aes_block_t k);
    start_block(ct, k);
    repeat (5) @(posedge clk);
    decReset <= 1'b1;
    @(negedge clk);
    check_value("pt_out", '0, pt_out);
    check_value("round_state", '0, i_aes_decrypt.i_sequencer.round_state);
  endtask

  initial begin
    aes_block_t rnd_ct;
    aes_block_t rnd_key;
    int         assert_fails;
    decReset     = 1'b1;
    ct_in        = '0;
    key          = '0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    lcg_state    = 32'd57;
    build_sbox_tables();

    // fips-197 appendix c.1
    check_value("model", 128'h00112233445566778899aabbccddeeff,
                model_decrypt(128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                              128'h000102030405060708090a0b0c0d0e0f));
    decrypt_and_check(128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                      128'h000102030405060708090a0b0c0d0e0f,
                      128'h00112233445566778899aabbccddeeff);

    for (int i = 0; i < 40; i++) begin
      rnd_ct  = random_block();
      rnd_key = random_block();
      if (i == 20) begin
        abort_mid_block(random_block(), random_block());  // next block must still work
      end
      decrypt_and_check(rnd_ct, rnd_key, model_decrypt(rnd_ct, rnd_key));
    end

    assert_fails = i_aes_decrypt.i_sequencer.i_assert.fail_cnt;
    $display("done: %0d value mismatches, %0d timeouts, %0d assertion failures",
             mismatch_cnt, timeout_cnt, assert_fails);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: aes_decrypt.f
+incdir+.
aes_dec_pkg.sv
aes_key_expand.sv
aes_inv_round.sv
aes_dec_sequencer.sv
aes_decrypt.sv
tb_clock_gen.sv
aes_decrypt_assert.sv
tb_aes_decrypt.sv

// File: Makefile
# Verilator simulation of the AES-128 decryption core
# any variable below can be set on the command line, e.g. make test TOP=...

VERILATOR ?= verilator
TOP       ?= tb_aes_decrypt
FILELIST  ?= aes_decrypt.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Everything OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

# the run passes only if the testbench prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
